/* all.f */
hw/botPermutePkg.sv
hw/syncFifo.sv
hw/batchBotFifo.sv
hw/batchScheduler.sv
hw/botPermuter.sv
hw/botPermuterWithFifo.sv
hw/permuteTop.sv
tests/permuteTop_properties.sv
tests/permuteTb.sv

/* Makefile */
# Verilator flow for the bot permutation engine

VERILATOR ?= verilator
TOP ?= permuteTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Simulation finished: PASS
LINT_FLAGS ?= -Wall
BUILD_FLAGS ?=
RUN_ARGS ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(BUILD_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

# Pass needs the pass line and no assertion error in the log
sim: $(BINARY)
	./$(BINARY) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)
	! grep -q "%Error" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/permuteTb.sv */
`timescale 1ns/1ps
`default_nettype none

module permuteTb
    import botPermutePkg::*;
();

    localparam int NUM_SOURCES = 4;
    localparam int FIFO_DEPTH_LOG2 = 5;
    localparam int BATCH_MAX_LOG2 = 6;

    // Letters of each ordering name as variable numbers A=0 B=1 C=2
    localparam int ORDER_VARS [PERM_COUNT][3] = '{
        '{0, 1, 2}, '{0, 2, 1}, '{1, 0, 2}, '{1, 2, 0}, '{2, 0, 1}, '{2, 1, 0}
    };

    typedef struct packed {
        logic isFinish;
        permOut_t beat;
    } expEntry_t;

    logic clk;
    logic rst;
    srcBeat_t srcBeat [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] srcValid;
    logic [NUM_SOURCES-1:0] srcReady;
    permOut_t permOut;
    logic permValid;
    logic permReady;
    logic batchFinished;
    logic [SRC_IDX_WIDTH-1:0] finishedSource;

    srcBeat_t pending [NUM_SOURCES][$];
    expEntry_t openBatch [NUM_SOURCES][$];
    expEntry_t expList [$];
    string testName;
    int errorCount;
    int beatCount;
    int finishCount;
    int expBeatTotal;
    int expFinishTotal;
    logic randomReady;
    logic timedOut;

    permuteTop #(
        .NUM_SOURCES(NUM_SOURCES),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
        .BATCH_MAX_LOG2(BATCH_MAX_LOG2)
    ) u_permuteTop (
        .clk(clk),
        .rst(rst),
        .srcBeat(srcBeat),
        .srcValid(srcValid),
        .srcReady(srcReady),
        .permOut(permOut),
        .permValid(permValid),
        .permReady(permReady),
        .batchFinished(batchFinished),
        .finishedSource(finishedSource)
    );

    bind permuteTop permuteTop_properties u_properties (
        .clk(clk),
        .rst(rst),
        .permOut(permOut),
        .permValid(permValid),
        .permReady(permReady),
        .batchFinished(batchFinished)
    );

    always #4 clk = ~clk;

    // Output slot k holds the k-th letter of the ordering name
    function automatic logic [7:0] permuteGroup(input logic [7:0] group, input int order);
        logic [7:0] result;
        logic [2:0] outIdx;
        logic [2:0] srcIdx;
        for (int j = 0; j < 8; j++) begin
            outIdx = 3'(j);
            srcIdx = '0;
            for (int k = 0; k < 3; k++) begin
                srcIdx[ORDER_VARS[order][k]] = outIdx[k];
            end
            result[j] = group[srcIdx];
        end
        return result;
    endfunction

    function automatic botWord_u permuteBot(input botWord_u bot, input int order);
        botWord_u result;
        for (int g = 0; g < 16; g++) begin
            result.groups[g] = permuteGroup(bot.groups[g], order);
        end
        return result;
    endfunction

    function automatic botWord_u randomBot();
        botWord_u result;
        result.flat = {$urandom, $urandom, $urandom, $urandom};
        return result;
    endfunction

    function automatic permMask_t randomMask(input logic allowEmpty);
        if (allowEmpty && $urandom_range(0, 3) == 0) begin
            return '0;
        end
        return permMask_t'($urandom_range(1, 63));
    endfunction

    task automatic checkValue(input string name, input logic [255:0] expected,
                              input logic [255:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errorCount++;
        end
    endtask

    // Last beat always carries a bot so finish pulses stay apart
    task automatic queueBatch(input int src, input int numBeats, input logic allowEmpty);
        srcBeat_t beat;
        for (int i = 0; i < numBeats; i++) begin
            beat.bot = randomBot();
            beat.last = i == numBeats - 1;
            beat.mask = randomMask(allowEmpty && !beat.last);
            pending[src].push_back(beat);
        end
    endtask

    // Expected beats follow mask order from bit 5 down
    task automatic recordBeat(input int src, input srcBeat_t beat);
        expEntry_t entry;
        for (int b = PERM_COUNT - 1; b >= 0; b--) begin
            if (beat.mask[b]) begin
                entry.isFinish = 1'b0;
                entry.beat.bot = permuteBot(beat.bot, PERM_COUNT - 1 - b);
                entry.beat.order = 3'(PERM_COUNT - 1 - b);
                entry.beat.source = SRC_IDX_WIDTH'(src);
                openBatch[src].push_back(entry);
                expBeatTotal++;
            end
        end
        if (beat.last) begin
            while (openBatch[src].size() > 0) begin
                expList.push_back(openBatch[src].pop_front());
            end
            entry = '0;
            entry.isFinish = 1'b1;
            entry.beat.source = SRC_IDX_WIDTH'(src);
            expList.push_back(entry);
            expFinishTotal++;
        end
    endtask

    task automatic waitDrained(input int limit);
        int cycles;
        logic busy;
        cycles = 0;
        busy = 1'b1;
        while (busy && cycles < limit) begin
            @(posedge clk);
            cycles++;
            busy = srcValid != '0 || expList.size() != 0;
            for (int s = 0; s < NUM_SOURCES; s++) begin
                if (pending[s].size() != 0) begin
                    busy = 1'b1;
                end
            end
        end
        if (busy) begin
            $display("ERROR: %s did not drain within %0d cycles, %0d entries still expected",
                     testName, limit, expList.size());
            errorCount++;
            timedOut = 1'b1;
        end
    endtask

    task automatic checkCounts();
        checkValue({testName, " beat count"}, 256'(expBeatTotal), 256'(beatCount));
        checkValue({testName, " finish count"}, 256'(expFinishTotal), 256'(finishCount));
    endtask

    // Closes in the same cycle are recorded highest source first
    always @(posedge clk) begin
        if (rst) begin
            srcValid <= '0;
            permReady <= 1'b0;
        end else begin
            for (int s = NUM_SOURCES - 1; s >= 0; s--) begin
                if (srcValid[s] && srcReady[s]) begin
                    recordBeat(s, srcBeat[s]);
                    void'(pending[s].pop_front());
                end
            end
            for (int s = 0; s < NUM_SOURCES; s++) begin
                if (pending[s].size() > 0) begin
                    srcBeat[s] <= pending[s][0];
                    srcValid[s] <= 1'b1;
                end else begin
                    srcValid[s] <= 1'b0;
                end
            end
            permReady <= randomReady ? $urandom_range(0, 3) != 0 : 1'b1;
        end
    end

    // A finish is handled before a beat of the same edge
    always @(posedge clk) begin
        expEntry_t front;
        if (!rst) begin
            if (batchFinished) begin
                finishCount++;
                if (expList.size() == 0) begin
                    $display("ERROR: %s got a finish pulse for source %0d with nothing expected",
                             testName, finishedSource);
                    errorCount++;
                end else begin
                    front = expList.pop_front();
                    checkValue({testName, " finish"}, 256'({front.isFinish, front.beat.source}),
                               256'({1'b1, finishedSource}));
                end
            end
            if (permValid && permReady) begin
                beatCount++;
                if (expList.size() == 0) begin
                    $display("ERROR: %s got an output beat with nothing expected", testName);
                    errorCount++;
                end else begin
                    front = expList.pop_front();
                    checkValue({testName, " beat"}, 256'({front.isFinish, front.beat}),
                               256'({1'b0, permOut}));
                end
            end
        end
    end

    initial begin
        int assertFails;
        srcBeat_t beat;
        void'($urandom(31));
        clk = 1'b0;
        rst = 1'b1;
        srcValid = '0;
        permReady = 1'b0;
        for (int s = 0; s < NUM_SOURCES; s++) begin
            srcBeat[s] = '0;
        end
        randomReady = 1'b0;
        timedOut = 1'b0;
        errorCount = 0;
        beatCount = 0;
        finishCount = 0;
        expBeatTotal = 0;
        expFinishTotal = 0;
        testName = "reset";
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        testName = "single source all orderings";
        beat.bot = randomBot();
        beat.mask = 6'b111111;
        beat.last = 1'b1;
        pending[0].push_back(beat);
        waitDrained(2000);
        checkValue({testName, " six beats"}, 256'(6), 256'(beatCount));
        checkCounts();

        if (!timedOut) begin
            testName = "random masks";
            for (int b = 0; b < 4; b++) begin
                queueBatch(1, int'($urandom_range(1, 6)), 1'b1);
            end
            waitDrained(4000);
            checkCounts();
        end

        if (!timedOut) begin
            testName = "close together";
            for (int s = 0; s < NUM_SOURCES; s++) begin
                queueBatch(s, int'($urandom_range(1, 3)), 1'b1);
                queueBatch(s, int'($urandom_range(1, 3)), 1'b1);
            end
            waitDrained(6000);
            checkCounts();
        end

        if (!timedOut) begin
            testName = "empty batch";
            beat.bot = randomBot();
            beat.mask = '0;
            beat.last = 1'b1;
            pending[2].push_back(beat);
            pending[3].push_back(beat);
            waitDrained(2000);
            checkCounts();
        end

        if (!timedOut) begin
            testName = "back pressure";
            randomReady = 1'b1;
            for (int b = 0; b < 4; b++) begin
                for (int s = 0; s < NUM_SOURCES; s++) begin
                    queueBatch(s, int'($urandom_range(1, 8)), 1'b1);
                end
            end
            waitDrained(20000);
            randomReady = 1'b0;
            checkCounts();
        end

        assertFails = u_permuteTop.u_properties.failCount;
        $display("Summary: %0d errors, %0d assertion failures, %0d of %0d beats, %0d of %0d %s",
                 errorCount, assertFails, beatCount, expBeatTotal, finishCount, expFinishTotal,
                 "finished batches");
        if (errorCount == 0 && assertFails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/permuteTop_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module permuteTop_properties
    import botPermutePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  permOut_t permOut,
    input  logic permValid,
    input  logic permReady,
    input  logic batchFinished
);

    int failCount = 0;

    // A stalled beat keeps its data until the sink takes it
    property stallHoldsBeat;
        @(posedge clk) disable iff (rst)
            permValid && !permReady |=> permValid && $stable(permOut);
    endproperty

    property finishIsPulse;
        @(posedge clk) disable iff (rst)
            batchFinished |=> !batchFinished;
    endproperty

    // Reset clears the output valids by the following edge
    property resetClearsOutputs;
        @(posedge clk)
            rst |=> !permValid && !batchFinished;
    endproperty

    assert property (stallHoldsBeat) else begin
        $error("permOut changed or dropped while stalled");
        failCount++;
    end

    assert property (finishIsPulse) else begin
        $error("batchFinished held longer than one cycle");
        failCount++;
    end

    assert property (resetClearsOutputs) else begin
        $error("output valid seen during reset");
        failCount++;
    end

endmodule

`default_nettype wire

/* hw/permuteTop.sv */
`timescale 1ns/1ps
`default_nettype none

module permuteTop
    import botPermutePkg::*;
#(
    parameter int NUM_SOURCES = 4,
    parameter int FIFO_DEPTH_LOG2 = 5,
    parameter int BATCH_MAX_LOG2 = 6
) (
    input  logic clk,
    input  logic rst,
    input  srcBeat_t srcBeat [NUM_SOURCES],
    input  logic [NUM_SOURCES-1:0] srcValid,
    output logic [NUM_SOURCES-1:0] srcReady,
    output permOut_t permOut,
    output logic permValid,
    input  logic permReady,
    output logic batchFinished,
    output logic [SRC_IDX_WIDTH-1:0] finishedSource
);

    permIn_t bots [NUM_SOURCES];
    logic [NUM_SOURCES-1:0] botValid;
    logic [NUM_SOURCES-1:0] botReady;
    logic [NUM_SOURCES-1:0] batchClosed;
    logic [NUM_SOURCES-1:0] closeAllowed;
    logic [BATCH_MAX_LOG2-1:0] batchLength [NUM_SOURCES];
    permIn_t schedOut;
    logic schedValid;
    logic schedReady;

    for (genvar i = 0; i < NUM_SOURCES; i++) begin : gSource
        batchBotFifo #(
            .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
            .BATCH_MAX_LOG2(BATCH_MAX_LOG2),
            .SOURCE_ID(i)
        ) u_batchBotFifo (
            .clk(clk),
            .rst(rst),
            .srcBeat(srcBeat[i]),
            .srcValid(srcValid[i]),
            .srcReady(srcReady[i]),
            .closeAllowed(closeAllowed[i]),
            .botOut(bots[i]),
            .botValid(botValid[i]),
            .botReady(botReady[i]),
            .batchClosed(batchClosed[i]),
            .batchLength(batchLength[i])
        );
    end

    batchScheduler #(
        .NUM_SOURCES(NUM_SOURCES),
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2),
        .BATCH_MAX_LOG2(BATCH_MAX_LOG2)
    ) u_batchScheduler (
        .clk(clk),
        .rst(rst),
        .batchClosed(batchClosed),
        .batchLength(batchLength),
        .closeAllowed(closeAllowed),
        .bots(bots),
        .botValid(botValid),
        .botReady(botReady),
        .schedOut(schedOut),
        .schedValid(schedValid),
        .schedReady(schedReady)
    );

    botPermuterWithFifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_botPermuterWithFifo (
        .clk(clk),
        .rst(rst),
        .inItem(schedOut),
        .inValid(schedValid),
        .inReady(schedReady),
        .permOut(permOut),
        .permValid(permValid),
        .permReady(permReady),
        .batchFinished(batchFinished),
        .finishedSource(finishedSource)
    );

endmodule

`default_nettype wire

/* hw/botPermuterWithFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module botPermuterWithFifo
    import botPermutePkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 5
) (
    input  logic clk,
    input  logic rst,
    input  permIn_t inItem,
    input  logic inValid,
    output logic inReady,
    output permOut_t permOut,
    output logic permValid,
    input  logic permReady,
    output logic batchFinished,
    output logic [SRC_IDX_WIDTH-1:0] finishedSource
);

    permIn_t fifoItem;
    logic fifoValid;
    logic fifoReady;
    logic endSeen;
    logic [SRC_IDX_WIDTH-1:0] endSource;

    // Absorbs scheduler traffic while a bot expands into several beats
    syncFifo #(
        .WIDTH($bits(permIn_t)),
        .DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_inputFifo (
        .clk(clk),
        .rst(rst),
        .inData(inItem),
        .inValid(inValid),
        .inReady(inReady),
        .outData(fifoItem),
        .outValid(fifoValid),
        .outReady(fifoReady)
    );

    botPermuter u_botPermuter (
        .clk(clk),
        .rst(rst),
        .inItem(fifoItem),
        .inValid(fifoValid),
        .inReady(fifoReady),
        .outItem(permOut),
        .outValid(permValid),
        .outReady(permReady),
        .endSeen(endSeen),
        .endSource(endSource)
    );

    // Finish pulse one cycle after the marker is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            batchFinished <= 1'b0;
        end else begin
            batchFinished <= endSeen;
        end
    end

    always_ff @(posedge clk) begin
        if (endSeen) begin
            finishedSource <= endSource;
        end
    end

endmodule

`default_nettype wire

/* hw/botPermuter.sv */
`timescale 1ns/1ps
`default_nettype none

module botPermuter
    import botPermutePkg::*;
(
    input  logic clk,
    input  logic rst,
    input  permIn_t inItem,
    input  logic inValid,
    output logic inReady,
    output permOut_t outItem,
    output logic outValid,
    input  logic outReady,
    output logic endSeen,
    output logic [SRC_IDX_WIDTH-1:0] endSource
);

    botWord_u heldBot;
    logic [SRC_IDX_WIDTH-1:0] heldSource;
    permMask_t remMask;
    permMask_t selBit;
    logic [2:0] ordIdx;
    logic lastBeat;
    logic inFire;
    logic outFire;
    botWord_u permuted;

    // Highest remaining mask bit picks the ordering of this beat
    always_comb begin
        ordIdx = 3'd0;
        selBit = '0;
        for (int b = 0; b < PERM_COUNT; b++) begin
            if (remMask[b]) begin
                ordIdx = 3'(PERM_COUNT - 1 - b);
                selBit = '0;
                selBit[b] = 1'b1;
            end
        end
    end

    assign outValid = |remMask;
    assign lastBeat = (remMask & ~selBit) == '0;
    assign outFire = outValid && outReady;
    // Next item is taken together with the final beat
    assign inReady = !outValid || (outReady && lastBeat);
    assign inFire = inValid && inReady;

    // Same reordering applied to each of the sixteen groups
    always_comb begin
        for (int g = 0; g < 16; g++) begin
            for (int j = 0; j < 8; j++) begin
                permuted.groups[g][j] = heldBot.groups[g][PERM_SRC_BIT[ordIdx][j]];
            end
        end
    end

    always_comb begin
        outItem.bot = permuted;
        outItem.order = ordIdx;
        outItem.source = heldSource;
    end

    assign endSeen = inFire && inItem.batchEnd;
    assign endSource = inItem.source;

    always_ff @(posedge clk) begin
        if (inFire) begin
            heldBot <= inItem.bot;
            heldSource <= inItem.source;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            remMask <= '0;
        end else if (inFire) begin
            // Markers carry no orderings to emit
            remMask <= inItem.batchEnd ? '0 : inItem.mask;
        end else if (outFire) begin
            remMask <= remMask & ~selBit;
        end
    end

endmodule

`default_nettype wire

/* hw/batchScheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module batchScheduler
    import botPermutePkg::*;
#(
    parameter int NUM_SOURCES = 4,
    parameter int FIFO_DEPTH_LOG2 = 5,
    parameter int BATCH_MAX_LOG2 = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic [NUM_SOURCES-1:0] batchClosed,
    input  logic [BATCH_MAX_LOG2-1:0] batchLength [NUM_SOURCES],
    output logic [NUM_SOURCES-1:0] closeAllowed,
    input  permIn_t bots [NUM_SOURCES],
    input  logic [NUM_SOURCES-1:0] botValid,
    output logic [NUM_SOURCES-1:0] botReady,
    output permIn_t schedOut,
    output logic schedValid,
    input  logic schedReady
);

    typedef struct packed {
        logic [SRC_IDX_WIDTH-1:0] source;
        logic [BATCH_MAX_LOG2-1:0] length;
    } queueEntry_t;

    queueEntry_t closeEntry;
    queueEntry_t headEntry;
    logic queueInReady;
    logic headValid;
    logic active;
    logic sendMarker;
    logic schedFire;
    logic [SRC_IDX_WIDTH-1:0] selSource;
    logic [BATCH_MAX_LOG2-1:0] remaining;

    // Fixed priority, highest closing source gets the queue slot
    always_comb begin
        logic higherClosing;
        higherClosing = 1'b0;
        closeEntry = '0;
        for (int i = NUM_SOURCES - 1; i >= 0; i--) begin
            closeAllowed[i] = queueInReady && !higherClosing;
            if (batchClosed[i] && !higherClosing) begin
                closeEntry.source = SRC_IDX_WIDTH'(i);
                closeEntry.length = batchLength[i];
            end
            higherClosing = higherClosing || batchClosed[i];
        end
    end

    syncFifo #(
        .WIDTH($bits(queueEntry_t)),
        .DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_batchQueue (
        .clk(clk),
        .rst(rst),
        .inData(closeEntry),
        .inValid(|batchClosed),
        .inReady(queueInReady),
        .outData(headEntry),
        .outValid(headValid),
        .outReady(!active)
    );

    // Count exhausted, only the end marker is left
    assign sendMarker = active && remaining == '0;
    assign schedFire = schedValid && schedReady;

    always_comb begin
        schedOut = '0;
        schedValid = 1'b0;
        botReady = '0;
        if (sendMarker) begin
            schedOut.batchEnd = 1'b1;
            schedOut.source = selSource;
            schedValid = 1'b1;
        end else if (active) begin
            for (int i = 0; i < NUM_SOURCES; i++) begin
                if (selSource == SRC_IDX_WIDTH'(i)) begin
                    schedOut = bots[i];
                    schedValid = botValid[i];
                    botReady[i] = schedReady;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!active && headValid) begin
            selSource <= headEntry.source;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            remaining <= '0;
        end else if (!active) begin
            if (headValid) begin
                active <= 1'b1;
                remaining <= headEntry.length;
            end
        end else if (schedFire) begin
            if (sendMarker) begin
                active <= 1'b0;
            end else begin
                remaining <= remaining - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/batchBotFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module batchBotFifo
    import botPermutePkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 5,
    parameter int BATCH_MAX_LOG2 = 6,
    parameter int SOURCE_ID = 0
) (
    input  logic clk,
    input  logic rst,
    input  srcBeat_t srcBeat,
    input  logic srcValid,
    output logic srcReady,
    input  logic closeAllowed,
    output permIn_t botOut,
    output logic botValid,
    input  logic botReady,
    output logic batchClosed,
    output logic [BATCH_MAX_LOG2-1:0] batchLength
);

    typedef struct packed {
        botWord_u bot;
        permMask_t mask;
    } storedBot_t;

    storedBot_t inEntry;
    storedBot_t outEntry;
    logic running;
    logic hasBots;
    logic roomForBot;
    logic fifoInReady;
    logic srcFire;
    logic [BATCH_MAX_LOG2-1:0] openCount;

    assign hasBots = |srcBeat.mask;
    // Stall once the open batch counter is saturated
    assign roomForBot = fifoInReady && !(&openCount);
    assign srcReady = running && (!hasBots || roomForBot) && (!srcBeat.last || closeAllowed);
    assign srcFire = srcValid && srcReady;

    // Close request, granted by the scheduler through closeAllowed
    assign batchClosed = srcValid && srcBeat.last && running && (!hasBots || roomForBot);
    assign batchLength = openCount + BATCH_MAX_LOG2'(hasBots);

    assign inEntry.bot = srcBeat.bot;
    assign inEntry.mask = srcBeat.mask;

    syncFifo #(
        .WIDTH($bits(storedBot_t)),
        .DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_botFifo (
        .clk(clk),
        .rst(rst),
        .inData(inEntry),
        .inValid(srcFire && hasBots),
        .inReady(fifoInReady),
        .outData(outEntry),
        .outValid(botValid),
        .outReady(botReady)
    );

    always_comb begin
        botOut.bot = outEntry.bot;
        botOut.mask = outEntry.mask;
        botOut.batchEnd = 1'b0;
        botOut.source = SRC_IDX_WIDTH'(SOURCE_ID);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            openCount <= '0;
        end else begin
            running <= 1'b1;
            if (srcFire && srcBeat.last) begin
                openCount <= '0;
            end else if (srcFire && hasBots) begin
                openCount <= openCount + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/syncFifo.sv */
`timescale 1ns/1ps
`default_nettype none

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic [WIDTH-1:0] inData,
    input  logic inValid,
    output logic inReady,
    output logic [WIDTH-1:0] outData,
    output logic outValid,
    input  logic outReady
);

    localparam int DEPTH = 2 ** DEPTH_LOG2;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2:0] count;
    logic [DEPTH_LOG2:0] countNext;
    logic inFire;
    logic memEmpty;
    logic loadOut;
    logic memWrite;
    logic memRead;

    assign inFire = inValid && inReady;
    assign memEmpty = count == '0;
    // Output register is empty or hands its word over this cycle
    assign loadOut = !outValid || outReady;
    assign memRead = loadOut && !memEmpty;
    // Bypass straight into the output register when nothing is stored
    assign memWrite = inFire && !(loadOut && memEmpty);
    assign countNext = count + (DEPTH_LOG2 + 1)'(memWrite) - (DEPTH_LOG2 + 1)'(memRead);

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[wrPtr] <= inData;
        end
        if (loadOut) begin
            outData <= memEmpty ? inData : mem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            outValid <= 1'b0;
            inReady <= 1'b0;
        end else begin
            if (memWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (memRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            count <= countNext;
            if (loadOut) begin
                outValid <= memRead || inFire;
            end
            // Registered full flag, judged on the next count
            inReady <= countNext != (DEPTH_LOG2 + 1)'(DEPTH);
        end
    end

endmodule

`default_nettype wire

/* hw/botPermutePkg.sv */
`default_nettype none

package botPermutePkg;

    // Source index field, room for up to eight sources
    localparam int SRC_IDX_WIDTH = 3;
    localparam int PERM_COUNT = 6;

    // Truth table of a seven-variable function
    typedef union packed {
        logic [127:0] flat;
        // Group g is the table over A, B, C with the upper four variables equal to g
        logic [15:0][7:0] groups;
    } botWord_u;

    // Bit 5 ABC, bit 4 ACB, bit 3 BAC, bit 2 BCA, bit 1 CAB, bit 0 CBA
    typedef logic [PERM_COUNT-1:0] permMask_t;

    typedef struct packed {
        botWord_u bot;
        permMask_t mask;
        logic last;
    } srcBeat_t;

    typedef struct packed {
        botWord_u bot;
        permMask_t mask;
        logic batchEnd;
        logic [SRC_IDX_WIDTH-1:0] source;
    } permIn_t;

    typedef struct packed {
        botWord_u bot;
        logic [2:0] order;
        logic [SRC_IDX_WIDTH-1:0] source;
    } permOut_t;

    // Entry [k][j] is the group bit that lands on bit j under ordering k
    localparam logic [2:0] PERM_SRC_BIT [PERM_COUNT][8] = '{
        '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd7},
        '{3'd0, 3'd1, 3'd4, 3'd5, 3'd2, 3'd3, 3'd6, 3'd7},
        '{3'd0, 3'd2, 3'd1, 3'd3, 3'd4, 3'd6, 3'd5, 3'd7},
        '{3'd0, 3'd2, 3'd4, 3'd6, 3'd1, 3'd3, 3'd5, 3'd7},
        '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2, 3'd6, 3'd3, 3'd7},
        '{3'd0, 3'd4, 3'd2, 3'd6, 3'd1, 3'd5, 3'd3, 3'd7}
    };

endpackage

`default_nettype wire
